// ==== all.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/inst_classify.sv
verilog/imm_extract.sv
verilog/exc_select.sv
verilog/ctrl_gen.sv
verilog/id_top.sv
test/tb_id_top.sv

// ==== test/decode_stim.txt ====
# iv word pc exc_we exc_code | valid class br_type imm rd rf_we mem_we ldst alu src1 src2 wb sign exc_we exc_code
# all hex; an invalid line with word 00000000 gets a random word and only valid, br_type, rf_we, mem_we are checked
1 001018a4 1c000000 0 00 1 1 0 00000000 04 1 0 8 001 2 2 01 1 0 00
1 001118a0 1c000004 0 00 1 1 0 00000000 00 0 0 8 002 2 2 01 1 0 00
1 00122507 1c000008 0 00 1 1 0 00000000 07 1 0 8 004 2 2 01 1 0 00
1 0012a507 1c00000c 0 00 1 1 0 00000000 07 1 0 8 008 2 2 01 1 0 00
1 0014316a 1c000010 0 00 1 1 0 00000000 0a 1 0 8 040 2 2 01 1 0 00
1 0014b16a 1c000014 0 00 1 1 0 00000000 0a 1 0 8 010 2 2 01 1 0 00
1 0015316a 1c000018 0 00 1 1 0 00000000 0a 1 0 8 020 2 2 01 1 0 00
1 0015b16a 1c00001c 0 00 1 1 0 00000000 0a 1 0 8 080 2 2 01 1 0 00
1 001718a4 1c000020 0 00 1 1 0 00000000 04 1 0 8 100 2 2 01 1 0 00
1 001798a4 1c000024 0 00 1 1 0 00000000 04 1 0 8 200 2 2 01 1 0 00
1 001818a4 1c000028 0 00 1 1 0 00000000 04 1 0 8 400 2 2 01 1 0 00
1 00408ca4 1c00002c 0 00 1 1 0 00000003 04 1 0 8 100 2 1 01 1 0 00
1 0044fca4 1c000030 0 00 1 1 0 0000001f 04 1 0 8 200 2 1 01 1 0 00
1 0048c0a4 1c000034 0 00 1 1 0 00000010 04 1 0 8 400 2 1 01 1 0 00
1 02bffca4 1c000038 0 00 1 1 0 ffffffff 04 1 0 8 001 2 1 01 1 0 00
1 022000a4 1c00003c 0 00 1 1 0 fffff800 04 1 0 8 004 2 1 01 1 0 00
1 025ffca4 1c000040 0 00 1 1 0 000007ff 04 1 0 8 008 2 1 01 1 0 00
1 037ffca4 1c000044 0 00 1 1 0 00000fff 04 1 0 8 010 2 1 01 1 0 00
1 03a000a4 1c000048 0 00 1 1 0 00000800 04 1 0 8 020 2 1 01 1 0 00
1 03c48ca4 1c00004c 0 00 1 1 0 00000123 04 1 0 8 080 2 1 01 1 0 00
1 142468a4 1c000050 0 00 1 1 0 12345000 04 1 0 8 001 4 1 01 1 0 00
1 1dffffe4 1c000054 0 00 1 1 0 fffff000 04 1 0 8 001 1 1 01 1 0 00
1 289ff0a4 1c000058 0 00 1 2 0 000007fc 04 1 0 0 001 2 1 02 1 0 00
1 287ff8a4 1c00005c 0 00 1 2 0 fffffffe 04 1 0 3 001 2 1 02 1 0 00
1 282000a4 1c000060 0 00 1 2 0 fffff800 04 1 0 2 001 2 1 02 1 0 00
1 2a4040a4 1c000064 0 00 1 2 0 00000010 04 1 0 5 001 2 1 02 1 0 00
1 2a0004a0 1c000068 0 00 1 2 0 00000001 00 0 0 4 001 2 1 02 1 0 00
1 29bff0a4 1c00006c 0 00 1 2 0 fffffffc 04 0 1 1 001 2 1 01 1 0 00
1 294020a4 1c000070 0 00 1 2 0 00000008 04 0 1 7 001 2 1 01 1 0 00
1 290000a4 1c000074 0 00 1 2 0 00000000 04 0 1 6 001 2 1 01 1 0 00
1 580010a4 1c000078 0 00 1 1 6 00000010 04 0 0 8 002 2 2 01 1 0 00
1 5ffffca4 1c00007c 0 00 1 1 7 fffffffc 04 0 0 8 002 2 2 01 1 0 00
1 620000a4 1c000080 0 00 1 1 8 fffe0000 04 0 0 8 004 2 2 01 1 0 00
1 640400a4 1c000084 0 00 1 1 9 00000400 04 0 0 8 004 2 2 01 1 0 00
1 69fffca4 1c000088 0 00 1 1 a 0001fffc 04 0 0 8 008 2 2 01 1 0 00
1 6c0008a4 1c00008c 0 00 1 1 b 00000008 04 0 0 8 008 2 2 01 1 0 00
1 4c000ca1 1c000090 0 00 1 1 3 0000000c 01 1 0 8 001 2 4 01 1 0 00
1 4c000020 1c000094 0 00 1 1 3 00000000 00 0 0 8 001 2 4 01 1 0 00
1 50004000 1c000098 0 00 1 1 4 00000040 00 0 0 8 800 2 4 01 1 0 00
1 540003ff 1c00009c 0 00 1 1 5 fffc0000 01 1 0 8 001 1 4 01 1 0 00
0 580010a4 1c0000a0 0 00 0 1 0 00000010 04 0 0 8 002 2 2 01 1 0 00
0 29bff0a4 1c0000a4 0 00 0 2 0 fffffffc 04 0 0 1 001 2 1 01 1 0 00
0 00000000 1c0000a8 0 00 0 1 0 00000000 00 0 0 8 800 2 4 01 1 1 0d
0 00000000 1c0000ac 0 00 0 1 0 00000000 00 0 0 8 800 2 4 01 1 1 0d
1 001c18a4 1c0000b0 0 00 1 4 0 00000000 04 1 0 8 800 2 2 04 1 0 00
1 001c98a4 1c0000b4 0 00 1 4 0 00000000 04 1 0 8 800 2 2 08 1 0 00
1 001d18a4 1c0000b8 0 00 1 4 0 00000000 04 1 0 8 800 2 2 08 0 0 00
1 002018a4 1c0000bc 0 00 1 8 0 00000000 04 1 0 8 800 2 2 10 1 0 00
1 002098a4 1c0000c0 0 00 1 8 0 00000000 04 1 0 8 800 2 2 20 1 0 00
1 002118a4 1c0000c4 0 00 1 8 0 00000000 04 1 0 8 800 2 2 10 0 0 00
1 002198a4 1c0000c8 0 00 1 8 0 00000000 04 1 0 8 800 2 2 20 0 0 00
1 002a0000 1c0000cc 0 00 1 1 0 00000000 00 0 0 8 800 2 4 01 1 1 0c
1 002b0000 1c0000d0 0 00 1 1 0 00000000 00 0 0 8 800 2 4 01 1 1 0b
1 ffffffe0 1c0000d4 0 00 0 1 0 00000000 00 0 0 8 800 2 4 01 1 1 0d
1 001018a4 1c0000d8 1 08 1 1 0 00000000 04 1 0 8 001 2 2 01 1 1 08
1 ffffffe0 1c0000dc 1 01 0 1 0 00000000 00 0 0 8 800 2 4 01 1 1 01
1 002a0000 1c0000e0 1 02 1 1 0 00000000 00 0 0 8 800 2 4 01 1 1 02
1 001018a4 1c0000e4 0 3f 1 1 0 00000000 04 1 0 8 001 2 2 01 1 0 00

// ==== test/tb_id_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_config.svh"

module tb_id_top;

    import decode_pkg::*;

    // one stimulus line with its inputs and expected bundle
    typedef struct packed {
        logic                 in_valid;
        logic [`ID_XLEN-1:0]  word;
        logic [`ID_XLEN-1:0]  pc;
        exc_t                 exc_in;
        logic                 full;
        logic                 valid;
        logic [3:0]           cls;
        logic [3:0]           br;
        logic [`ID_XLEN-1:0]  imm;
        logic [`ID_REG_W-1:0] rd;
        logic                 rf_we;
        logic                 mem_we;
        logic [3:0]           ldst;
        logic [11:0]          alu;
        logic [3:0]           src1;
        logic [3:0]           src2;
        logic [5:0]           wb;
        logic                 sign_bit;
        exc_t                 exc;
    } vector_t;

    logic        clk;
    logic        i_reset;
    logic        i_valid;
    fetch_pkt_t  i_fetch;
    decode_pkt_t o_decode;

    vector_t vec_q[$];
    vector_t pending[$];
    int      seed;
    int      mismatch_cnt;
    int      other_cnt;
    logic    loaded;

    id_top id_top_i (
        .i_clk    (clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_fetch  (i_fetch),
        .o_decode (o_decode)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
        assert (got_val === exp_val) else begin
            $display("ERR %0t o_decode.%s expected %h actual %h",
                     $time, name, exp_val, got_val);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reset_state();
        check_field("valid", 32'd0, o_decode.valid);
        check_field("rf_we", 32'd0, o_decode.rf_we);
        check_field("mem_we", 32'd0, o_decode.mem_we);
        check_field("exc.we", 32'd0, o_decode.exc.we);
        check_field("br_type", BR_NONE, o_decode.br_type);
    endtask

    // stores and conditional branches read rd, everything else rk
    function automatic logic [`ID_REG_W-1:0] raddr2_from_word(input vector_t v);
        logic is_store;
        logic is_cond_branch;
        is_store = (v.ldst == LDST_ST_W) || (v.ldst == LDST_ST_H) || (v.ldst == LDST_ST_B);
        // beq through bgeu sit on major opcodes 0x16 to 0x1b
        is_cond_branch = (v.word[31:26] >= 6'h16) && (v.word[31:26] <= 6'h1b);
        if (is_store || is_cond_branch) begin
            return v.word[4:0];
        end
        return v.word[14:10];
    endfunction

    // legality shows in valid under the strobe, else in the illegal code
    function automatic logic lawful_from_vector(input vector_t v);
        if (v.in_valid) begin
            return v.valid;
        end
        return !(v.exc.we && (v.exc.code == `ID_ECODE_INE));
    endfunction

    task automatic compare_outputs(input vector_t v);
        check_field("valid", v.valid, o_decode.valid);
        check_field("br_type", v.br, o_decode.br_type);
        check_field("rf_we", v.rf_we, o_decode.rf_we);
        check_field("mem_we", v.mem_we, o_decode.mem_we);
        // random words only carry the gating checks
        if (v.full) begin
            check_field("pc", v.pc, o_decode.pc);
            check_field("inst_class", v.cls, o_decode.inst_class);
            check_field("imm", v.imm, o_decode.imm);
            check_field("rd", v.rd, o_decode.rd);
            check_field("raddr1", v.word[9:5], o_decode.raddr1);
            check_field("raddr2", raddr2_from_word(v), o_decode.raddr2);
            check_field("ldst_type", v.ldst, o_decode.ldst_type);
            check_field("alu_op", v.alu, o_decode.alu_op);
            check_field("src1_sel", v.src1, o_decode.src1_sel);
            check_field("src2_sel", v.src2, o_decode.src2_sel);
            check_field("wb_sel", v.wb, o_decode.wb_sel);
            check_field("sign_bit", v.sign_bit, o_decode.sign_bit);
            check_field("exc.we", v.exc.we, o_decode.exc.we);
            check_field("exc.code", v.exc.code, o_decode.exc.code);
            if (v.in_valid || !v.exc_in.we) begin
                check_field("lawful", lawful_from_vector(v), o_decode.lawful);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[20];
        vector_t     v;
        fd = $fopen("test/decode_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/decode_stim.txt");
            other_cnt++;
        end
        else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                            f[19]);
                if (n != 20) begin
                    $display("stimulus line has %0d fields instead of 20: %s", n, line);
                    other_cnt++;
                end
                else begin
                    v.in_valid    = f[0][0];
                    v.word        = f[1];
                    v.pc          = f[2];
                    v.exc_in.we   = f[3][0];
                    v.exc_in.code = f[4][6:0];
                    v.full        = f[0][0] || (f[1] != 0);
                    v.valid       = f[5][0];
                    v.cls         = f[6][3:0];
                    v.br          = f[7][3:0];
                    v.imm         = f[8];
                    v.rd          = f[9][4:0];
                    v.rf_we       = f[10][0];
                    v.mem_we      = f[11][0];
                    v.ldst        = f[12][3:0];
                    v.alu         = f[13][11:0];
                    v.src1        = f[14][3:0];
                    v.src2        = f[15][3:0];
                    v.wb          = f[16][5:0];
                    v.sign_bit    = f[17][0];
                    v.exc.we      = f[18][0];
                    v.exc.code    = f[19][6:0];
                    if (!v.full) begin
                        v.word = $random(seed);
                    end
                    vec_q.push_back(v);
                end
            end
            $fclose(fd);
        end
        if (vec_q.size() == 0) begin
            $display("no stimulus vectors were loaded");
            other_cnt++;
        end
    endtask

    // bl and st.w alternate with a flagged exception so every gated field would rise
    task automatic reset_under_load();
        for (int c = 0; c < 8; c++) begin
            i_valid          = 1'b1;
            i_fetch.word     = c[0] ? 32'h29bff0a4 : 32'h540003ff;
            i_fetch.pc       = 32'h1c000100 + c * 4;
            i_fetch.exc.we   = 1'b1;
            i_fetch.exc.code = 7'h01;
            @(negedge clk);
            check_reset_state();
        end
    endtask

    // each vector comes out two rising edges after it is driven
    task automatic run_vectors();
        foreach (vec_q[k]) begin
            if (pending.size() == 2) begin
                compare_outputs(pending.pop_front());
            end
            i_valid      = vec_q[k].in_valid;
            i_fetch.word = vec_q[k].word;
            i_fetch.pc   = vec_q[k].pc;
            i_fetch.exc  = vec_q[k].exc_in;
            pending.push_back(vec_q[k]);
            @(negedge clk);
        end
        i_valid = 1'b0;
        i_fetch = '0;
        while (pending.size() > 0) begin
            compare_outputs(pending.pop_front());
            @(negedge clk);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d field mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Regression passed");
        end
        else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        seed         = 32'h5c41;
        mismatch_cnt = 0;
        other_cnt    = 0;
        loaded       = 1'b0;
        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_fetch      = '0;
        load_vectors();
        loaded = 1'b1;
        reset_under_load();
        i_reset = 1'b0;
        run_vectors();
        finish_run();
    end

    // watchdog
    initial begin
        wait (loaded);
        #((vec_q.size() + 20) * 10);
        $display("timeout: the run did not finish within %0d clock cycles", vec_q.size() + 20);
        other_cnt++;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog/ctrl_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_config.svh"

module ctrl_gen (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire decode_pkg::class_pkt_t i_class,
    output decode_pkg::decode_pkt_t     o_decode
);

    import decode_pkg::*;

    inst_op_e             op;
    logic [`ID_XLEN-1:0]  imm;
    exc_t                 exc;
    inst_class_e          cls;
    br_type_e             br;
    ldst_type_e           ldst;
    wb_sel_e              wb;
    alu_op_e              alu;
    src1_sel_e            src1;
    src2_sel_e            src2;
    logic                 is_store;
    logic                 is_cbr;
    logic                 is_link;
    logic [`ID_REG_W-1:0] rd;
    logic                 rf_we;
    decode_pkt_t          dec;

    assign op = i_class.op;

    imm_extract imm_extract_i (
        .i_word (i_class.word),
        .i_op   (op),
        .o_imm  (imm)
    );

    exc_select exc_select_i (
        .i_exc_in (i_class.exc),
        .i_op     (op),
        .o_exc    (exc)
    );

    //////////////////////////////////////////////////
    // per-field decode
    //////////////////////////////////////////////////

    assign is_store = op inside {OP_ST_W, OP_ST_H, OP_ST_B};
    assign is_cbr   = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign is_link  = op inside {OP_BL, OP_JIRL};

    always_comb begin
        case (op)
            OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU,
            OP_ST_W, OP_ST_H, OP_ST_B:       cls = CLS_LDST;
            OP_MUL, OP_MULH, OP_MULHU:       cls = CLS_MUL;
            OP_DIV, OP_MOD, OP_DIVU, OP_MODU: cls = CLS_DIV;
            default:                         cls = CLS_OTHER;
        endcase

        case (op)
            OP_JIRL: br = BR_JIRL;
            OP_B:    br = BR_B;
            OP_BL:   br = BR_BL;
            OP_BEQ:  br = BR_BEQ;
            OP_BNE:  br = BR_BNE;
            OP_BLT:  br = BR_BLT;
            OP_BGE:  br = BR_BGE;
            OP_BLTU: br = BR_BLTU;
            OP_BGEU: br = BR_BGEU;
            default: br = BR_NONE;
        endcase

        case (op)
            OP_LD_W:  ldst = LDST_LD_W;
            OP_ST_W:  ldst = LDST_ST_W;
            OP_LD_B:  ldst = LDST_LD_B;
            OP_LD_H:  ldst = LDST_LD_H;
            OP_LD_BU: ldst = LDST_LD_BU;
            OP_LD_HU: ldst = LDST_LD_HU;
            OP_ST_B:  ldst = LDST_ST_B;
            OP_ST_H:  ldst = LDST_ST_H;
            default:  ldst = LDST_OTHERS;
        endcase

        case (op)
            OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU: wb = WB_LOAD;
            OP_MUL:                                       wb = WB_MUL_LO;
            OP_MULH, OP_MULHU:                            wb = WB_MUL_HI;
            OP_DIV, OP_DIVU:                              wb = WB_QUO;
            OP_MOD, OP_MODU:                              wb = WB_REM;
            default:                                      wb = WB_ALU;
        endcase
    end

    // alu operation and operand sources
    always_comb begin
        case (op)
            OP_ADD, OP_ADDI, OP_LU12I, OP_PCADDU12I, OP_BL, OP_JIRL,
            OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU,
            OP_ST_W, OP_ST_H, OP_ST_B:           alu = ALU_ADD;
            OP_SUB, OP_BEQ, OP_BNE:              alu = ALU_SUB;
            OP_SLT, OP_SLTI, OP_BLT, OP_BGE:     alu = ALU_SLT;
            OP_SLTU, OP_SLTUI, OP_BLTU, OP_BGEU: alu = ALU_SLTU;
            OP_AND, OP_ANDI:                     alu = ALU_AND;
            OP_OR, OP_ORI:                       alu = ALU_OR;
            OP_NOR:                              alu = ALU_NOR;
            OP_XOR, OP_XORI:                     alu = ALU_XOR;
            OP_SLL, OP_SLLI:                     alu = ALU_SLL;
            OP_SRL, OP_SRLI:                     alu = ALU_SRL;
            OP_SRA, OP_SRAI:                     alu = ALU_SRA;
            default:                             alu = ALU_NONE;
        endcase

        case (op)
            OP_BL, OP_PCADDU12I: src1 = SRC1_PC;
            OP_LU12I:            src1 = SRC1_ZERO;
            default:             src1 = SRC1_RF;
        endcase

        // link instructions add four to the pc
        case (op)
            OP_ADDI, OP_SLTI, OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI,
            OP_SLLI, OP_SRLI, OP_SRAI, OP_LU12I, OP_PCADDU12I,
            OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU,
            OP_ST_W, OP_ST_H, OP_ST_B:                 src2 = SRC2_IMM;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_NOR, OP_XOR,
            OP_SLL, OP_SRL, OP_SRA,
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_MUL, OP_MULH, OP_MULHU,
            OP_DIV, OP_MOD, OP_DIVU, OP_MODU:          src2 = SRC2_RF;
            default:                                   src2 = SRC2_FOUR;
        endcase
    end

    //////////////////////////////////////////////////
    // register file ports
    //////////////////////////////////////////////////

    assign rd = (op == OP_BL) ? `ID_LINK_REG : i_class.word.r3.rd;

    // no write for r0, stores and plain branches
    assign rf_we = i_class.valid && (rd != '0) && !is_store && !((br != BR_NONE) && !is_link);

    always_comb begin
        dec.lawful     = (op != OP_ILLEGAL);
        dec.valid      = i_class.valid && (op != OP_ILLEGAL);
        dec.pc         = i_class.pc;
        dec.inst_class = cls;
        dec.br_type    = i_class.valid ? br : BR_NONE;
        dec.imm        = imm;
        dec.rd         = rd;
        dec.rf_we      = rf_we;
        dec.raddr1     = i_class.word.r3.rj;
        // stores and compares read rd as the second operand
        dec.raddr2     = (is_store || is_cbr) ? i_class.word.r3.rd : i_class.word.r3.rk;
        dec.src1_sel   = src1;
        dec.src2_sel   = src2;
        dec.alu_op     = alu;
        dec.mem_we     = is_store && i_class.valid;
        dec.ldst_type  = ldst;
        dec.wb_sel     = wb;
        dec.sign_bit   = !(op inside {OP_MULHU, OP_DIVU, OP_MODU});
        dec.exc        = exc;
    end

    always_ff @(posedge i_clk) begin
        o_decode <= dec;
        if (i_reset) begin
            o_decode.valid   <= 1'b0;
            o_decode.rf_we   <= 1'b0;
            o_decode.mem_we  <= 1'b0;
            o_decode.br_type <= BR_NONE;
            o_decode.exc.we  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath and register file
`define ID_XLEN      32
`define ID_REG_W     5

// bl writes its return address here
`define ID_LINK_REG  5'd1

// exception codes
`define ID_ECODE_W   7
`define ID_ECODE_INE 7'h0D
`define ID_ECODE_BRK 7'h0C
`define ID_ECODE_SYS 7'h0B

`endif

// ==== verilog/decode_pkg.sv ====
`default_nettype none
`include "decode_config.svh"

package decode_pkg;

    //////////////////////////////////////////////////
    // instruction word formats
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [16:0]          opcode;
        logic [`ID_REG_W-1:0] rk;
        logic [`ID_REG_W-1:0] rj;
        logic [`ID_REG_W-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]           opcode;
        logic [11:0]          imm12;
        logic [`ID_REG_W-1:0] rj;
        logic [`ID_REG_W-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [15:0]          offs16;
        logic [`ID_REG_W-1:0] rj;
        logic [`ID_REG_W-1:0] rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]           opcode;
        logic [19:0]          si20;
        logic [`ID_REG_W-1:0] rd;
    } fmt_1ri20_t;

    // b and bl split the 26-bit offset, high part in the low bits
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [9:0]  offs_hi10;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
        fmt_1ri20_t ri20;
        fmt_i26_t   i26;
    } inst_word_u;

    //////////////////////////////////////////////////
    // control encodings
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_ADDI, OP_LU12I, OP_PCADDU12I,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTUI,
        OP_AND, OP_OR, OP_NOR, OP_XOR, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ST_W, OP_ST_H, OP_ST_B,
        OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_B, OP_BL, OP_JIRL,
        OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_MOD, OP_DIVU, OP_MODU,
        OP_BREAK, OP_SYSCALL,
        OP_ILLEGAL
    } inst_op_e;

    // one-hot, selects the back-end pipe
    typedef enum logic [3:0] {
        CLS_OTHER = 4'h1,
        CLS_LDST  = 4'h2,
        CLS_MUL   = 4'h4,
        CLS_DIV   = 4'h8
    } inst_class_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'b0000,
        BR_JIRL = 4'b0011,
        BR_B    = 4'b0100,
        BR_BL   = 4'b0101,
        BR_BEQ  = 4'b0110,
        BR_BNE  = 4'b0111,
        BR_BLT  = 4'b1000,
        BR_BGE  = 4'b1001,
        BR_BLTU = 4'b1010,
        BR_BGEU = 4'b1011
    } br_type_e;

    typedef enum logic [3:0] {
        LDST_LD_W   = 4'b0000,
        LDST_ST_W   = 4'b0001,
        LDST_LD_B   = 4'b0010,
        LDST_LD_H   = 4'b0011,
        LDST_LD_BU  = 4'b0100,
        LDST_LD_HU  = 4'b0101,
        LDST_ST_B   = 4'b0110,
        LDST_ST_H   = 4'b0111,
        LDST_OTHERS = 4'b1000
    } ldst_type_e;

    typedef enum logic [11:0] {
        ALU_ADD  = 12'h001,
        ALU_SUB  = 12'h002,
        ALU_SLT  = 12'h004,
        ALU_SLTU = 12'h008,
        ALU_AND  = 12'h010,
        ALU_OR   = 12'h020,
        ALU_NOR  = 12'h040,
        ALU_XOR  = 12'h080,
        ALU_SLL  = 12'h100,
        ALU_SRL  = 12'h200,
        ALU_SRA  = 12'h400,
        ALU_NONE = 12'h800
    } alu_op_e;

    // write-back source mux, one-hot
    typedef enum logic [5:0] {
        WB_ALU    = 6'h01,
        WB_LOAD   = 6'h02,
        WB_MUL_LO = 6'h04,
        WB_MUL_HI = 6'h08,
        WB_QUO    = 6'h10,
        WB_REM    = 6'h20
    } wb_sel_e;

    typedef enum logic [3:0] {
        SRC1_PC   = 4'h1,
        SRC1_RF   = 4'h2,
        SRC1_ZERO = 4'h4
    } src1_sel_e;

    typedef enum logic [3:0] {
        SRC2_IMM  = 4'h1,
        SRC2_RF   = 4'h2,
        SRC2_FOUR = 4'h4
    } src2_sel_e;

    //////////////////////////////////////////////////
    // stage packets
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                   we;
        logic [`ID_ECODE_W-1:0] code;
    } exc_t;

    typedef struct packed {
        inst_word_u          word;
        logic [`ID_XLEN-1:0] pc;
        exc_t                exc;
    } fetch_pkt_t;

    typedef struct packed {
        logic                valid;
        inst_word_u          word;
        logic [`ID_XLEN-1:0] pc;
        inst_op_e            op;
        exc_t                exc;
    } class_pkt_t;

    typedef struct packed {
        logic                 lawful;
        logic                 valid;
        logic [`ID_XLEN-1:0]  pc;
        inst_class_e          inst_class;
        br_type_e             br_type;
        logic [`ID_XLEN-1:0]  imm;
        logic [`ID_REG_W-1:0] rd;
        logic                 rf_we;
        logic [`ID_REG_W-1:0] raddr1;
        logic [`ID_REG_W-1:0] raddr2;
        src1_sel_e            src1_sel;
        src2_sel_e            src2_sel;
        alu_op_e              alu_op;
        logic                 mem_we;
        ldst_type_e           ldst_type;
        wb_sel_e              wb_sel;
        logic                 sign_bit;
        exc_t                 exc;
    } decode_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/exc_select.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_config.svh"

module exc_select (
    input  wire decode_pkg::exc_t     i_exc_in,
    input  wire decode_pkg::inst_op_e i_op,
    output decode_pkg::exc_t          o_exc
);

    import decode_pkg::*;

    always_comb begin
        // an earlier stage already flagged this word
        if (i_exc_in.we) begin
            o_exc = i_exc_in;
        end
        else if (i_op == OP_ILLEGAL) begin
            o_exc.we   = 1'b1;
            o_exc.code = `ID_ECODE_INE;
        end
        else if (i_op == OP_BREAK) begin
            o_exc.we   = 1'b1;
            o_exc.code = `ID_ECODE_BRK;
        end
        else if (i_op == OP_SYSCALL) begin
            o_exc.we   = 1'b1;
            o_exc.code = `ID_ECODE_SYS;
        end
        else begin
            o_exc.we   = 1'b0;
            o_exc.code = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_top (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_valid,
    input  wire decode_pkg::fetch_pkt_t i_fetch,
    output decode_pkg::decode_pkt_t     o_decode
);

    import decode_pkg::*;

    // stage one to stage two
    class_pkt_t class_pkt;

    inst_classify inst_classify_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_fetch (i_fetch),
        .o_class (class_pkt)
    );

    ctrl_gen ctrl_gen_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_class  (class_pkt),
        .o_decode (o_decode)
    );

endmodule

`default_nettype wire

// ==== verilog/imm_extract.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_config.svh"

module imm_extract (
    input  wire decode_pkg::inst_word_u i_word,
    input  wire decode_pkg::inst_op_e   i_op,
    output logic [`ID_XLEN-1:0]         o_imm
);

    import decode_pkg::*;

    always_comb begin
        case (i_op)
            // pc-relative word offsets
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JIRL: begin
                o_imm = {{14{i_word.ri16.offs16[15]}}, i_word.ri16.offs16, 2'b00};
            end
            OP_B, OP_BL: begin
                o_imm = {{4{i_word.i26.offs_hi10[9]}}, i_word.i26.offs_hi10,
                         i_word.i26.offs16, 2'b00};
            end
            OP_LD_W, OP_LD_H, OP_LD_B, OP_LD_HU, OP_LD_BU,
            OP_ST_W, OP_ST_H, OP_ST_B,
            OP_ADDI, OP_SLTI, OP_SLTUI: begin
                o_imm = {{20{i_word.ri12.imm12[11]}}, i_word.ri12.imm12};
            end
            // logical immediates are unsigned
            OP_ANDI, OP_ORI, OP_XORI: begin
                o_imm = {20'd0, i_word.ri12.imm12};
            end
            OP_LU12I, OP_PCADDU12I: begin
                o_imm = {i_word.ri20.si20, 12'd0};
            end
            OP_SLLI, OP_SRLI, OP_SRAI: begin
                o_imm = {27'd0, i_word.r3.rk};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/inst_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_classify (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_valid,
    input  wire decode_pkg::fetch_pkt_t i_fetch,
    output decode_pkg::class_pkt_t      o_class
);

    import decode_pkg::*;

    inst_op_e op;

    //////////////////////////////////////////////////
    // opcode match
    //////////////////////////////////////////////////

    // opcode spaces of the four formats do not overlap
    always_comb begin
        op = OP_ILLEGAL;

        case (i_fetch.word.r3.opcode)
            17'h00020: op = OP_ADD;
            17'h00022: op = OP_SUB;
            17'h00024: op = OP_SLT;
            17'h00025: op = OP_SLTU;
            17'h00028: op = OP_NOR;
            17'h00029: op = OP_AND;
            17'h0002a: op = OP_OR;
            17'h0002b: op = OP_XOR;
            17'h0002e: op = OP_SLL;
            17'h0002f: op = OP_SRL;
            17'h00030: op = OP_SRA;
            17'h00038: op = OP_MUL;
            17'h00039: op = OP_MULH;
            17'h0003a: op = OP_MULHU;
            17'h00040: op = OP_DIV;
            17'h00041: op = OP_MOD;
            17'h00042: op = OP_DIVU;
            17'h00043: op = OP_MODU;
            17'h00054: op = OP_BREAK;
            17'h00056: op = OP_SYSCALL;
            // immediate shifts keep ui5 in the rk slot
            17'h00081: op = OP_SLLI;
            17'h00089: op = OP_SRLI;
            17'h00091: op = OP_SRAI;
            default: ;
        endcase

        case (i_fetch.word.ri12.opcode)
            10'h008: op = OP_SLTI;
            10'h009: op = OP_SLTUI;
            10'h00a: op = OP_ADDI;
            10'h00d: op = OP_ANDI;
            10'h00e: op = OP_ORI;
            10'h00f: op = OP_XORI;
            10'h0a0: op = OP_LD_B;
            10'h0a1: op = OP_LD_H;
            10'h0a2: op = OP_LD_W;
            10'h0a4: op = OP_ST_B;
            10'h0a5: op = OP_ST_H;
            10'h0a6: op = OP_ST_W;
            10'h0a8: op = OP_LD_BU;
            10'h0a9: op = OP_LD_HU;
            default: ;
        endcase

        case (i_fetch.word.ri20.opcode)
            7'h0a:   op = OP_LU12I;
            7'h0e:   op = OP_PCADDU12I;
            default: ;
        endcase

        // b and bl share the 6-bit opcode position
        case (i_fetch.word.ri16.opcode)
            6'h13:   op = OP_JIRL;
            6'h14:   op = OP_B;
            6'h15:   op = OP_BL;
            6'h16:   op = OP_BEQ;
            6'h17:   op = OP_BNE;
            6'h18:   op = OP_BLT;
            6'h19:   op = OP_BGE;
            6'h1a:   op = OP_BLTU;
            6'h1b:   op = OP_BGEU;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        o_class.valid <= i_valid;
        o_class.word  <= i_fetch.word;
        o_class.pc    <= i_fetch.pc;
        o_class.op    <= op;
        o_class.exc   <= i_fetch.exc;
        if (i_reset) begin
            o_class.valid  <= 1'b0;
            o_class.exc.we <= 1'b0;
        end
    end

endmodule

`default_nettype wire
